// ==== rtl/soc_map_pkg.sv ====
//////////////////////////////
// upper 12 address bits select the region
// only region 12'h001 is local data RAM
//////////////////////////////
`default_nettype none

package soc_map_pkg;

  localparam int ADDR_W   = 32;
  localparam int REGION_W = 12;

  localparam logic [REGION_W-1:0] LOCAL_REGION = 12'h001;

  // one load/store address, seen by region or by word
  typedef union packed {
    struct packed {
      logic [REGION_W-1:0]        region;
      logic [ADDR_W-REGION_W-1:0] offset;
    } region_v;
    struct packed {
      logic [ADDR_W-3:0] index;
      logic [1:0]        byte_off;
    } word_v;
  } lsu_addr_u;

endpackage

`default_nettype wire

// ==== rtl/lsu_pkg.sv ====
//////////////////////////////
// 32-bit words with 4 byte enables
//////////////////////////////
`default_nettype none

package lsu_pkg;

  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;

  // which target owes the next response
  typedef enum logic {
    RESP_RAM = 1'b0,
    RESP_BUS = 1'b1
  } resp_src_e;

endpackage

`default_nettype wire

// ==== rtl/lsu_if.sv ====
//////////////////////////////
// req/gnt request, one rvalid per transfer
//////////////////////////////
`default_nettype none

interface lsu_if;

  logic                          req;
  logic                          gnt;
  logic                          rvalid;
  soc_map_pkg::lsu_addr_u        addr;
  logic                          we;
  logic [lsu_pkg::BE_W-1:0]      be;
  logic [lsu_pkg::DATA_W-1:0]    wdata;
  logic [lsu_pkg::DATA_W-1:0]    rdata;

  // side that issues requests
  modport requester (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata
  );

  // side that serves them
  modport responder (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata
  );

endinterface

`default_nettype wire

// ==== rtl/lsu_router.sv ====
//////////////////////////////
// responses return in issue order
// a target switch waits for the other side to drain
//////////////////////////////
`default_nettype none

module lsu_router (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic                         lsu_req_i,
  input  wire soc_map_pkg::lsu_addr_u       lsu_addr_i,
  input  wire logic                         lsu_we_i,
  input  wire logic [lsu_pkg::BE_W-1:0]     lsu_be_i,
  input  wire logic [lsu_pkg::DATA_W-1:0]   lsu_wdata_i,
  output logic                              lsu_gnt_o,
  output logic                              lsu_rvalid_o,
  output logic [lsu_pkg::DATA_W-1:0]        lsu_rdata_o,
  lsu_if.requester                          ram_bus,
  lsu_if.requester                          ext_bus
);

  logic                is_local;
  logic                ram_xfer;
  logic                ext_xfer;
  logic [1:0]          ram_cnt;
  logic                ext_pend;
  lsu_pkg::resp_src_e  resp_src;

  assign is_local = (lsu_addr_i.region_v.region == soc_map_pkg::LOCAL_REGION);

  // hold back a request while the other target still owes a response
  assign ram_bus.req = lsu_req_i & is_local & ~ext_pend;
  assign ext_bus.req = lsu_req_i & ~is_local & (ram_cnt == 2'd0);

  assign ram_bus.addr  = lsu_addr_i;
  assign ram_bus.we    = lsu_we_i;
  assign ram_bus.be    = lsu_be_i;
  assign ram_bus.wdata = lsu_wdata_i;
  assign ext_bus.addr  = lsu_addr_i;
  assign ext_bus.we    = lsu_we_i;
  assign ext_bus.be    = lsu_be_i;
  assign ext_bus.wdata = lsu_wdata_i;

  assign ram_xfer  = ram_bus.req & ram_bus.gnt;
  assign ext_xfer  = ext_bus.req & ext_bus.gnt;
  assign lsu_gnt_o = ram_xfer | ext_xfer;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ram_cnt  <= 2'd0;
      ext_pend <= 1'b0;
      resp_src <= lsu_pkg::RESP_RAM;
    end
    else
    begin
      if (ram_xfer && !ram_bus.rvalid)
        ram_cnt <= ram_cnt + 2'd1;
      else if (!ram_xfer && ram_bus.rvalid)
        ram_cnt <= ram_cnt - 2'd1;

      // a new bus transfer may start in the cycle the last one returns
      if (ext_xfer)
        ext_pend <= 1'b1;
      else if (ext_bus.rvalid)
        ext_pend <= 1'b0;

      if (ram_xfer)
        resp_src <= lsu_pkg::RESP_RAM;
      else if (ext_xfer)
        resp_src <= lsu_pkg::RESP_BUS;
    end
  end

  assign lsu_rvalid_o = ram_bus.rvalid | ext_bus.rvalid;
  assign lsu_rdata_o  = (resp_src == lsu_pkg::RESP_BUS) ? ext_bus.rdata : ram_bus.rdata;

  // both targets never answer in the same cycle
  a_no_resp_overlap: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(ram_bus.rvalid && ext_bus.rvalid)
  );

endmodule

`default_nettype wire

// ==== rtl/data_ram_port.sv ====
//////////////////////////////
// size must be a power of two bytes
// contents undefined after reset
//////////////////////////////
`default_nettype none

module data_ram_port #(
  parameter int DATA_RAM_SIZE = 4096
) (
  input  wire logic  clk,
  input  wire logic  rst_n,
  lsu_if.responder   bus
);

  localparam int WORDS = DATA_RAM_SIZE / lsu_pkg::BE_W;
  localparam int IDX_W = $clog2(WORDS);

  logic [lsu_pkg::DATA_W-1:0] mem [0:WORDS-1];
  logic [lsu_pkg::DATA_W-1:0] rdata_q;
  logic                       rvalid_q;
  logic [IDX_W-1:0]           idx;
  logic                       xfer;

  // always ready, one access per cycle
  assign bus.gnt = bus.req;
  assign xfer    = bus.req & bus.gnt;
  assign idx     = bus.addr.word_v.index[IDX_W-1:0];

  always_ff @(posedge clk)
  begin
    if (xfer && bus.we)
    begin
      for (int b = 0; b < lsu_pkg::BE_W; b++)
      begin
        if (bus.be[b])
          mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
      end
    end
  end

  // read before write on the same word
  always_ff @(posedge clk)
  begin
    if (xfer)
      rdata_q <= mem[idx];
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rvalid_q <= 1'b0;
    else
      rvalid_q <= xfer;
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;

  a_rvalid_one_cycle: assert property (
    @(posedge clk) disable iff (!rst_n)
    bus.rvalid |-> $past(bus.req && bus.gnt)
  );

endmodule

`default_nettype wire

// ==== rtl/apb_master_bridge.sv ====
//////////////////////////////
// one transfer at a time
// pslverr is not supported
//////////////////////////////
`default_nettype none

module apb_master_bridge (
  input  wire logic                              clk,
  input  wire logic                              rst_n,
  lsu_if.responder                               bus,
  output logic [soc_map_pkg::ADDR_W-1:0]         paddr_o,
  output logic                                   psel_o,
  output logic                                   penable_o,
  output logic                                   pwrite_o,
  output logic [lsu_pkg::DATA_W-1:0]             pwdata_o,
  output logic [lsu_pkg::BE_W-1:0]               pstrb_o,
  input  wire logic [lsu_pkg::DATA_W-1:0]        prdata_i,
  input  wire logic                              pready_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } apb_state_e;

  apb_state_e                     state;
  logic [soc_map_pkg::ADDR_W-1:0] paddr_q;
  logic                           pwrite_q;
  logic [lsu_pkg::DATA_W-1:0]     pwdata_q;
  logic [lsu_pkg::BE_W-1:0]       pstrb_q;
  logic [lsu_pkg::DATA_W-1:0]     rdata_q;
  logic                           rvalid_q;
  logic                           xfer;

  assign bus.gnt = (state == ST_IDLE);
  assign xfer    = bus.req & bus.gnt;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= ST_IDLE;
      rvalid_q <= 1'b0;
    end
    else
    begin
      rvalid_q <= 1'b0;
      case (state)
        ST_IDLE:
          if (xfer)
            state <= ST_SETUP;
        ST_SETUP:
          state <= ST_ACCESS;
        ST_ACCESS:
          if (pready_i)
          begin
            state    <= ST_IDLE;
            rvalid_q <= 1'b1;
          end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // request fields held for the whole APB transfer
  always_ff @(posedge clk)
  begin
    if (xfer)
    begin
      paddr_q  <= bus.addr;
      pwrite_q <= bus.we;
      pwdata_q <= bus.wdata;
      pstrb_q  <= bus.we ? bus.be : '0;
    end
    if (state == ST_ACCESS && pready_i)
      rdata_q <= prdata_i;
  end

  assign paddr_o    = paddr_q;
  assign pwrite_o   = pwrite_q;
  assign pwdata_o   = pwdata_q;
  assign pstrb_o    = pstrb_q;
  assign psel_o     = (state != ST_IDLE);
  assign penable_o  = (state == ST_ACCESS);
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;

  // access phase always follows a cycle with psel already high
  a_penable_in_sel: assert property (
    @(posedge clk) disable iff (!rst_n)
    penable_o |-> psel_o && $past(psel_o)
  );

endmodule

`default_nettype wire

// ==== rtl/core_data_region.sv ====
//////////////////////////////
// local RAM answers in 1 cycle
// APB side latency varies
//////////////////////////////
`default_nettype none

module core_data_region #(
  parameter int DATA_RAM_SIZE = 4096
) (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire logic                          lsu_req_i,
  input  wire logic [soc_map_pkg::ADDR_W-1:0] lsu_addr_i,
  input  wire logic                          lsu_we_i,
  input  wire logic [lsu_pkg::BE_W-1:0]      lsu_be_i,
  input  wire logic [lsu_pkg::DATA_W-1:0]    lsu_wdata_i,
  output logic                               lsu_gnt_o,
  output logic                               lsu_rvalid_o,
  output logic [lsu_pkg::DATA_W-1:0]         lsu_rdata_o,
  output logic [soc_map_pkg::ADDR_W-1:0]     paddr_o,
  output logic                               psel_o,
  output logic                               penable_o,
  output logic                               pwrite_o,
  output logic [lsu_pkg::DATA_W-1:0]         pwdata_o,
  output logic [lsu_pkg::BE_W-1:0]           pstrb_o,
  input  wire logic [lsu_pkg::DATA_W-1:0]    prdata_i,
  input  wire logic                          pready_i
);

  lsu_if ram_bus ();
  lsu_if ext_bus ();

  lsu_router u_router (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .lsu_req_i    ( lsu_req_i    ),
    .lsu_addr_i   ( lsu_addr_i   ),
    .lsu_we_i     ( lsu_we_i     ),
    .lsu_be_i     ( lsu_be_i     ),
    .lsu_wdata_i  ( lsu_wdata_i  ),
    .lsu_gnt_o    ( lsu_gnt_o    ),
    .lsu_rvalid_o ( lsu_rvalid_o ),
    .lsu_rdata_o  ( lsu_rdata_o  ),
    .ram_bus      ( ram_bus      ),
    .ext_bus      ( ext_bus      )
  );

  data_ram_port #(
    .DATA_RAM_SIZE ( DATA_RAM_SIZE )
  ) u_data_ram (
    .clk   ( clk     ),
    .rst_n ( rst_n   ),
    .bus   ( ram_bus )
  );

  apb_master_bridge u_apb_bridge (
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .bus       ( ext_bus   ),
    .paddr_o   ( paddr_o   ),
    .psel_o    ( psel_o    ),
    .penable_o ( penable_o ),
    .pwrite_o  ( pwrite_o  ),
    .pwdata_o  ( pwdata_o  ),
    .pstrb_o   ( pstrb_o   ),
    .prdata_i  ( prdata_i  ),
    .pready_i  ( pready_i  )
  );

endmodule

`default_nettype wire

// ==== dv/lsu_checker.sv ====
//////////////////////////////
// expects six words per vector, same file as the driver
//////////////////////////////
`default_nettype none

module lsu_checker #(
  parameter int NUM_VEC = 16
) (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        req_i,
  input  wire logic [31:0] addr_i,
  input  wire logic        gnt_i,
  input  wire logic        rvalid_i,
  input  wire logic [31:0] rdata_i,
  input  wire logic [31:0] paddr_i,
  input  wire logic        psel_i,
  input  wire logic        penable_i,
  input  wire logic        pwrite_i,
  input  wire logic [31:0] pwdata_i,
  input  wire logic [3:0]  pstrb_i,
  input  wire logic        pready_i,
  output int               error_count_o,
  output int               resp_count_o
);

  logic [31:0] vec [0:NUM_VEC*6-1];
  int          pend_q [$];
  int          gnt_cyc [NUM_VEC];
  bit          test_bad [NUM_VEC];
  int          next_idx;
  int          ext_idx;
  int          cyc;
  int          ram_out;
  int          bus_out;
  int          head;
  bit          req_seen;
  bit          apb_busy;
  logic [31:0] paddr_q;
  logic [31:0] pwdata_q;
  logic [3:0]  pstrb_q;
  logic        pwrite_q;

  initial
  begin
    $readmemh("dv/lsu_vectors.hex", vec);
    error_count_o = 0;
    resp_count_o  = 0;
    next_idx      = 0;
    ext_idx       = 0;
    cyc           = 0;
    req_seen      = 1'b0;
    apb_busy      = 1'b0;
    foreach (test_bad[i])
      test_bad[i] = 1'b0;
  end

  function automatic bit is_local(input logic [31:0] a);
    return a[31:20] == 12'h001;
  endfunction

  task automatic value_error(input string sig, input logic [31:0] got,
                             input logic [31:0] exp, input int idx);
    $display("[ERROR] test %0d %s got %h expected %h", idx, sig, got, exp);
    error_count_o++;
    test_bad[idx] = 1'b1;
  endtask

  task automatic text_error(input string msg);
    $display("[ERROR] %s at cycle %0d", msg, cyc);
    error_count_o++;
  endtask

  always @(posedge clk)
  begin
    if (rst_n)
    begin
      cyc++;
      if (!req_seen && (rvalid_i || psel_i || penable_i))
        text_error("response or APB activity before the first request");
      if (gnt_i && !req_i)
        text_error("grant without a request");
      if (req_i)
        req_seen = 1'b1;

      // counts of the other target, taken before this cycle's response
      ram_out = 0;
      bus_out = 0;
      foreach (pend_q[k])
      begin
        if (is_local(vec[6*pend_q[k]+1]))
          ram_out++;
        else
          bus_out++;
      end

      if (rvalid_i)
      begin
        if (pend_q.size() == 0)
          text_error("response with no request outstanding");
        else
        begin
          head = pend_q.pop_front();
          if (is_local(vec[6*head+1]) && (cyc - gnt_cyc[head] != 1))
          begin
            text_error("local response did not come one cycle after the grant");
            test_bad[head] = 1'b1;
          end
          if (vec[6*head] == 32'd0 && rdata_i !== vec[6*head+4])
            value_error("lsu_rdata_o", rdata_i, vec[6*head+4], head);
          $display("test %0d %s %h: %s", head, (vec[6*head] != 0) ? "write" : "read",
                   vec[6*head+1], test_bad[head] ? "FAIL" : "ok");
          resp_count_o++;
        end
      end

      if (req_i && gnt_i)
      begin
        if (next_idx >= NUM_VEC)
          text_error("grant after the last vector");
        else
        begin
          if (is_local(addr_i) && bus_out != 0)
            text_error("local grant while a bus response was outstanding");
          if (!is_local(addr_i) && ram_out != 0)
            text_error("bus grant while a RAM response was outstanding");
          gnt_cyc[next_idx] = cyc;
          if (!is_local(addr_i))
            ext_idx = next_idx;
          pend_q.push_back(next_idx);
          next_idx++;
        end
      end

      // APB phase and stability rules
      if (penable_i && !psel_i)
        text_error("penable high without psel");
      if (psel_i && !penable_i)
      begin
        if (apb_busy)
          text_error("second setup cycle without an access phase");
        apb_busy = 1'b1;
        paddr_q  = paddr_i;
        pwrite_q = pwrite_i;
        pwdata_q = pwdata_i;
        pstrb_q  = pstrb_i;
        if (paddr_i !== vec[6*ext_idx+1])
          value_error("paddr_o", paddr_i, vec[6*ext_idx+1], ext_idx);
        if (pwrite_i !== vec[6*ext_idx][0])
          value_error("pwrite_o", {31'd0, pwrite_i}, vec[6*ext_idx], ext_idx);
        if (vec[6*ext_idx][0] && pwdata_i !== vec[6*ext_idx+3])
          value_error("pwdata_o", pwdata_i, vec[6*ext_idx+3], ext_idx);
        if (pstrb_i !== (vec[6*ext_idx][0] ? vec[6*ext_idx+2][3:0] : 4'h0))
          value_error("pstrb_o", {28'd0, pstrb_i},
                      vec[6*ext_idx][0] ? vec[6*ext_idx+2] : 32'd0, ext_idx);
      end
      else if (psel_i && penable_i)
      begin
        if (!apb_busy)
          text_error("access phase without a setup cycle");
        if (paddr_i !== paddr_q || pwrite_i !== pwrite_q ||
            pwdata_i !== pwdata_q || pstrb_i !== pstrb_q)
        begin
          text_error("APB fields changed before pready");
          test_bad[ext_idx] = 1'b1;
        end
        if (pready_i)
          apb_busy = 1'b0;
      end
      else if (apb_busy)
        text_error("psel dropped before pready");
    end
  end

  task automatic print_summary();
    int failed;
    failed = 0;
    foreach (test_bad[i])
      if (test_bad[i])
        failed++;
    $display("summary: %0d tests, %0d responses, %0d failed, %0d errors",
             NUM_VEC, resp_count_o, failed, error_count_o);
  endtask

endmodule

`default_nettype wire

// ==== dv/tb_core_data_region.sv ====
//////////////////////////////
// run from the project root so the vector file is found
//////////////////////////////
`default_nettype none

module tb_core_data_region;

  localparam int NUM_VEC      = 16;
  localparam int RESET_CYCLES = 8;
  localparam int MAX_WAIT     = 6;
  localparam int LIMIT        = NUM_VEC * (MAX_WAIT + 6) + RESET_CYCLES + 8;

  logic        clk;
  logic        rst_n;
  logic        lsu_req;
  logic [31:0] lsu_addr;
  logic        lsu_we;
  logic [3:0]  lsu_be;
  logic [31:0] lsu_wdata;
  logic        lsu_gnt;
  logic        lsu_rvalid;
  logic [31:0] lsu_rdata;
  logic [31:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [3:0]  pstrb;
  logic [31:0] prdata;
  logic        pready;
  int          error_count;
  int          resp_count;
  logic [31:0] vec [0:NUM_VEC*6-1];
  logic [31:0] slave_mem [0:15];
  logic [31:0] lfsr;
  logic [3:0]  sidx;
  int          ext_wait;
  int          wait_left;
  int          cyc;
  bit          granted;

  core_data_region #(
    .DATA_RAM_SIZE ( 4096 )
  ) UUT (
    .clk          ( clk        ),
    .rst_n        ( rst_n      ),
    .lsu_req_i    ( lsu_req    ),
    .lsu_addr_i   ( lsu_addr   ),
    .lsu_we_i     ( lsu_we     ),
    .lsu_be_i     ( lsu_be     ),
    .lsu_wdata_i  ( lsu_wdata  ),
    .lsu_gnt_o    ( lsu_gnt    ),
    .lsu_rvalid_o ( lsu_rvalid ),
    .lsu_rdata_o  ( lsu_rdata  ),
    .paddr_o      ( paddr      ),
    .psel_o       ( psel       ),
    .penable_o    ( penable    ),
    .pwrite_o     ( pwrite     ),
    .pwdata_o     ( pwdata     ),
    .pstrb_o      ( pstrb      ),
    .prdata_i     ( prdata     ),
    .pready_i     ( pready     )
  );

  lsu_checker #(
    .NUM_VEC ( NUM_VEC )
  ) u_checker (
    .clk           ( clk         ),
    .rst_n         ( rst_n       ),
    .req_i         ( lsu_req     ),
    .addr_i        ( lsu_addr    ),
    .gnt_i         ( lsu_gnt     ),
    .rvalid_i      ( lsu_rvalid  ),
    .rdata_i       ( lsu_rdata   ),
    .paddr_i       ( paddr       ),
    .psel_i        ( psel        ),
    .penable_i     ( penable     ),
    .pwrite_i      ( pwrite      ),
    .pwdata_i      ( pwdata      ),
    .pstrb_i       ( pstrb       ),
    .pready_i      ( pready      ),
    .error_count_o ( error_count ),
    .resp_count_o  ( resp_count  )
  );

  initial
    clk = 1'b0;
  always #4 clk = ~clk;

  // Galois form, taps 32,22,2,1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  always @(posedge clk)
  begin
    cyc++;
    if (cyc >= LIMIT)
    begin
      $display("timeout: run passed %0d cycles without all responses", LIMIT);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // APB slave, wait states from the vector plus 0..3 random
  always @(negedge clk)
  begin
    if (psel && !penable)
    begin
      sidx = paddr[5:2];
      if (pwrite)
        for (int b = 0; b < 4; b++)
          if (pstrb[b])
            slave_mem[sidx][8*b +: 8] = pwdata[8*b +: 8];
      prdata = slave_mem[sidx];
      lfsr = lfsr_next(lfsr);
      wait_left = ext_wait + (lfsr[0] ? 2 : 0);
      lfsr = lfsr_next(lfsr);
      wait_left = wait_left + (lfsr[0] ? 1 : 0);
      pready = 1'b0;
    end
    else if (psel && penable)
    begin
      // pready only in the last access cycle
      pready = (wait_left == 0);
      if (wait_left != 0)
        wait_left--;
    end
    else
      pready = 1'b0;
  end

  initial
  begin
    $readmemh("dv/lsu_vectors.hex", vec);
    for (int i = 0; i < 16; i++)
      slave_mem[i] = 32'hf00d_0000 | i;
    lfsr      = 32'h5c31;
    cyc       = 0;
    ext_wait  = 0;
    wait_left = 0;
    rst_n     = 1'b0;
    lsu_req   = 1'b0;
    lsu_addr  = '0;
    lsu_we    = 1'b0;
    lsu_be    = '0;
    lsu_wdata = '0;
    prdata    = '0;
    pready    = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // quiet cycles for the post-reset check
    repeat (4) @(negedge clk);

    for (int i = 0; i < NUM_VEC; i++)
    begin
      @(negedge clk);
      lsu_req   = 1'b1;
      lsu_we    = vec[6*i][0];
      lsu_addr  = vec[6*i+1];
      lsu_be    = vec[6*i+2][3:0];
      lsu_wdata = vec[6*i+3];
      granted   = 1'b0;
      while (!granted)
      begin
        @(posedge clk);
        granted = lsu_gnt;
      end
      if (vec[6*i+1][31:20] != 12'h001)
        ext_wait = int'(vec[6*i+5][3:0]);
    end
    @(negedge clk);
    lsu_req = 1'b0;

    while (resp_count != NUM_VEC)
      @(negedge clk);
    repeat (2) @(negedge clk);
    u_checker.print_summary();
    if (error_count == 0 && resp_count == NUM_VEC)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/soc_map_pkg.sv
rtl/lsu_pkg.sv
rtl/lsu_if.sv
rtl/lsu_router.sv
rtl/data_ram_port.sv
rtl/apb_master_bridge.sv
rtl/core_data_region.sv
dv/lsu_checker.sv
dv/tb_core_data_region.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run from the project root, fail on any reported check failure
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f \
  --top-module tb_core_data_region -Mdir obj_dir -o sim > build.log 2>&1 &&
./obj_dir/sim > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation FAILED"; exit 1; } ||
{ echo "simulation passed"; exit 0; }

// ==== dv/lsu_vectors.hex ====
// op(1=write) address byte_enable write_data expected_read_data apb_waits
// local region 0x001xxxxx, everything else goes out on APB
00000001 00100000 0000000f 11223344 00000000 00000000
00000001 00100004 0000000f 55667788 00000000 00000000
00000001 00100004 00000003 aabbccdd 00000000 00000000
00000001 00100000 0000000c 99000000 00000000 00000000
00000000 00100000 00000000 00000000 99003344 00000000
00000000 00100004 00000000 00000000 5566ccdd 00000000
00000001 40000010 0000000f cafef00d 00000000 00000002
00000000 40000010 00000000 00000000 cafef00d 00000001
00000000 40000020 00000000 00000000 f00d0008 00000003
00000001 40000010 00000006 00beef00 00000000 00000000
00000000 00100000 00000000 00000000 99003344 00000000
00000000 40000010 00000000 00000000 cabeef0d 00000002
00000000 00100004 00000000 00000000 5566ccdd 00000000
00000001 00100008 0000000f 0badc0de 00000000 00000000
00000000 00100008 00000000 00000000 0badc0de 00000000
00000000 4000003c 00000000 00000000 f00d000f 00000000
